/* Makefile */
# Verilator flow for the convolution tap engine.
# Every variable below can be overridden on the command line.

VERILATOR ?= verilator
TOP       ?= tb_conv_tap_engine
RTL_TOP   ?= conv_tap_engine
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
TIMESCALE ?= 1ns/100ps
VFLAGS    ?= --timing --assert --timescale $(TIMESCALE)
PASS_TEXT ?= all tests passed

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -o V$(TOP)

# The run passes only if the pass message shows up as a line of its own.
sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

/* build.f */
+incdir+testbench
common/lenet_pkg.sv
design/approx_mul8.sv
design/mac_lane.sv
design/act_combiner.sv
design/conv_tap_engine.sv
testbench/tb_conv_tap_engine.sv

/* common/lenet_pkg.sv */
package lenet_pkg;

    //////////////////////////////////////////////////////////////////////
    // Datapath widths
    //////////////////////////////////////////////////////////////////////

    localparam int ACT_W     = 8;   // Unsigned activation.
    localparam int WGT_W     = 8;   // Unsigned weight.
    localparam int PROD_W    = 16;  // Full 8x8 product.
    localparam int CORR_W    = 13;  // Correction vectors reach weight 2^12.
    localparam int TAPS      = 4;   // Taps per convolution window.
    localparam int LANE_TAPS = 2;   // Taps handled by one lane.
    localparam int LANE_W    = 17;  // Sum of two products.
    localparam int ACC_W     = 20;  // Signed accumulator.
    localparam int BIAS_W    = 20;  // Signed bias.

    localparam int OUT_SHIFT = 6;   // Requantization shift.
    localparam int OUT_MAX   = 255; // Largest 8-bit activation.

    //////////////////////////////////////////////////////////////////////
    // Bundles passed between blocks
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [TAPS-1:0][ACT_W-1:0] act;
        logic [TAPS-1:0][WGT_W-1:0] wgt;
    } window_t;

    // Half a window, as seen by one lane.
    typedef struct packed {
        logic [LANE_TAPS-1:0][ACT_W-1:0] act;
        logic [LANE_TAPS-1:0][WGT_W-1:0] wgt;
    } tap_pair_t;

    typedef struct packed {
        logic              valid;
        logic [LANE_W-1:0] sum;
    } lane_sum_t;

endpackage

/* design/act_combiner.sv */
module act_combiner (
    input  logic                               clk,
    input  logic                               arst_n,
    input  lenet_pkg::lane_sum_t               lane_a,
    input  lenet_pkg::lane_sum_t               lane_b,
    input  logic signed [lenet_pkg::BIAS_W-1:0] bias,
    output logic                               out_valid,
    output logic [lenet_pkg::ACT_W-1:0]        act_out
);
    import lenet_pkg::*;

    logic signed [ACC_W-1:0] acc;
    logic        [ACC_W-1:0] relu;
    logic        [ACC_W-1:0] shifted;
    logic        [ACT_W-1:0] act_next;

    //////////////////////////////////////////////////////////////////////
    // Accumulate and requantize
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        acc = $signed(ACC_W'(lane_a.sum))
            + $signed(ACC_W'(lane_b.sum))
            + ACC_W'(bias); // Bias sign carries into the sum.
    end

    always_comb begin
        if (acc < 0) begin
            relu = '0;
        end else begin
            relu = ACC_W'(acc);
        end
    end

    assign shifted = relu >> OUT_SHIFT;

    always_comb begin
        if (shifted > ACC_W'(OUT_MAX)) begin
            act_next = ACT_W'(OUT_MAX); // Clip large outputs.
        end else begin
            act_next = shifted[ACT_W-1:0];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Output register
    //////////////////////////////////////////////////////////////////////

    // The lanes run in lockstep, so lane_a's valid speaks for both.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
            act_out   <= '0;
        end else begin
            out_valid <= lane_a.valid;
            if (lane_a.valid) begin
                act_out <= act_next; // Holds its value while idle.
            end
        end
    end

endmodule

/* design/approx_mul8.sv */
module approx_mul8 (
    input  logic [lenet_pkg::ACT_W-1:0]  x,
    input  logic [lenet_pkg::WGT_W-1:0]  y,
    output logic [lenet_pkg::PROD_W-1:0] z
);
    import lenet_pkg::*;

    logic [ACT_W-1:0][WGT_W-1:0] pp; // Partial-product rows, one per bit of x.

    logic [CORR_W-1:0] corr1;
    logic [CORR_W-1:0] corr2;
    logic [CORR_W-1:0] corr3;
    logic [CORR_W-1:0] corr4;
    logic [CORR_W-1:0] corr5;

    //////////////////////////////////////////////////////////////////////
    // Partial products
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < ACT_W; i++) begin
            pp[i] = y & {WGT_W{x[i]}};
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Compression of the low rows
    //////////////////////////////////////////////////////////////////////

    // Rows 0 to 5 are never added as such; neighbouring rows are merged
    // bit by bit into a handful of sparse correction vectors instead.
    always_comb begin
        corr1 = '0;
        corr2 = '0;
        corr3 = '0;
        corr4 = '0;
        corr5 = '0;

        corr1[5]  = pp[2][2] ^ pp[3][1];
        corr1[6]  = pp[2][4] & pp[3][3];
        corr1[7]  = pp[0][6] ^ pp[1][5];
        corr1[8]  = pp[1][7];
        corr1[9]  = pp[2][6] & pp[3][5];
        corr1[10] = pp[3][7];
        corr1[11] = pp[4][7] & pp[5][6];
        corr1[12] = pp[5][7];

        corr2[5]  = pp[4][1] | pp[5][0];
        corr2[8]  = pp[2][6] | pp[3][5];
        corr2[9]  = pp[2][7] | pp[3][6];
        corr2[10] = pp[4][6] & pp[5][5];
        corr2[11] = pp[4][7] | pp[5][6];

        corr3[8]  = pp[4][3] | pp[5][2];
        corr3[9]  = pp[4][4] | pp[5][3];
        corr3[10] = pp[4][6] | pp[5][5];

        corr4[9]  = pp[4][5] & pp[5][4];

        corr5[9]  = pp[4][5] | pp[5][4];
    end

    //////////////////////////////////////////////////////////////////////
    // Final sum
    //////////////////////////////////////////////////////////////////////

    // Only rows 6 and 7 are exact, so any x with bits 0-5 clear multiplies exactly.
    always_comb begin
        z = (PROD_W'(pp[6]) << 6)
          + (PROD_W'(pp[7]) << 7)
          + PROD_W'(corr1)
          + PROD_W'(corr2)
          + PROD_W'(corr3)
          + PROD_W'(corr4)
          + PROD_W'(corr5);
    end

endmodule

/* design/conv_tap_engine.sv */
module conv_tap_engine (
    input  logic                               clk,
    input  logic                               arst_n,
    input  logic                               in_valid,
    input  lenet_pkg::window_t                 window,
    input  logic signed [lenet_pkg::BIAS_W-1:0] bias,
    output logic                               out_valid,
    output logic [lenet_pkg::ACT_W-1:0]        act_out
);
    import lenet_pkg::*;

    tap_pair_t               taps_a;
    tap_pair_t               taps_b;
    lane_sum_t               lane_a_sum;
    lane_sum_t               lane_b_sum;
    logic signed [BIAS_W-1:0] bias_q;

    // Low taps feed lane a, high taps feed lane b.
    always_comb begin
        for (int i = 0; i < LANE_TAPS; i++) begin
            taps_a.act[i] = window.act[i];
            taps_a.wgt[i] = window.wgt[i];
            taps_b.act[i] = window.act[LANE_TAPS+i];
            taps_b.wgt[i] = window.wgt[LANE_TAPS+i];
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            bias_q <= bias; // Travels alongside the lane stage.
        end
    end

    mac_lane lane_a (
        .clk      (clk),
        .arst_n   (arst_n),
        .in_valid (in_valid),
        .taps     (taps_a),
        .lane     (lane_a_sum)
    );

    mac_lane lane_b (
        .clk      (clk),
        .arst_n   (arst_n),
        .in_valid (in_valid),
        .taps     (taps_b),
        .lane     (lane_b_sum)
    );

    act_combiner combiner (
        .clk       (clk),
        .arst_n    (arst_n),
        .lane_a    (lane_a_sum),
        .lane_b    (lane_b_sum),
        .bias      (bias_q),
        .out_valid (out_valid),
        .act_out   (act_out)
    );

endmodule

/* design/mac_lane.sv */
module mac_lane (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 in_valid,
    input  lenet_pkg::tap_pair_t taps,
    output lenet_pkg::lane_sum_t lane
);
    import lenet_pkg::*;

    logic [LANE_TAPS-1:0][PROD_W-1:0] prod;
    logic [LANE_W-1:0]                sum_next;

    //////////////////////////////////////////////////////////////////////
    // Multipliers
    //////////////////////////////////////////////////////////////////////

    for (genvar i = 0; i < LANE_TAPS; i++) begin : g_mul
        approx_mul8 mul_inst (
            .x (taps.act[i]),
            .y (taps.wgt[i]),
            .z (prod[i])
        );
    end

    always_comb begin
        sum_next = '0;
        for (int i = 0; i < LANE_TAPS; i++) begin
            sum_next = sum_next + LANE_W'(prod[i]); // One extra bit holds the carry.
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Lane register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            lane.valid <= 1'b0;
            lane.sum   <= '0;
        end else begin
            lane.valid <= in_valid;
            if (in_valid) begin
                lane.sum <= sum_next; // Held between strobes.
            end
        end
    end

endmodule

/* testbench/approx_model.svh */
`ifndef APPROX_MODEL_SVH
`define APPROX_MODEL_SVH

//////////////////////////////////////////////////////////////////////
// Behavioral model of the approximate multiplier and the engine
//////////////////////////////////////////////////////////////////////

localparam int OP_AND = 0;
localparam int OP_OR  = 1;
localparam int OP_XOR = 2;

// One correction bit joins x[ra]*y[ca] with x[rb]*y[cb] and sits at weight 2^w.
function automatic int corr_term(logic [7:0] x, logic [7:0] y, int w,
                                 int ra, int ca, int rb, int cb, int op);
    logic a;
    logic b;
    logic hit;
    a = x[ra] & y[ca];
    b = x[rb] & y[cb];
    case (op)
        OP_AND:  hit = a & b;
        OP_XOR:  hit = a ^ b;
        default: hit = a | b;
    endcase
    return hit ? (1 << w) : 0;
endfunction

function automatic int approx_product(logic [7:0] x, logic [7:0] y);
    int p;
    p = 0;
    if (x[6]) p += int'(y) << 6; // Exact upper rows.
    if (x[7]) p += int'(y) << 7;
    p += corr_term(x, y, 5, 2, 2, 3, 1, OP_XOR);
    p += corr_term(x, y, 5, 4, 1, 5, 0, OP_OR);
    p += corr_term(x, y, 6, 2, 4, 3, 3, OP_AND);
    p += corr_term(x, y, 7, 0, 6, 1, 5, OP_XOR);
    p += corr_term(x, y, 8, 1, 7, 1, 7, OP_OR);  // A single bit joined with itself.
    p += corr_term(x, y, 8, 2, 6, 3, 5, OP_OR);
    p += corr_term(x, y, 8, 4, 3, 5, 2, OP_OR);
    p += corr_term(x, y, 9, 2, 6, 3, 5, OP_AND);
    p += corr_term(x, y, 9, 2, 7, 3, 6, OP_OR);
    p += corr_term(x, y, 9, 4, 4, 5, 3, OP_OR);
    p += corr_term(x, y, 9, 4, 5, 5, 4, OP_AND);
    p += corr_term(x, y, 9, 4, 5, 5, 4, OP_OR);
    p += corr_term(x, y, 10, 3, 7, 3, 7, OP_OR);
    p += corr_term(x, y, 10, 4, 6, 5, 5, OP_AND);
    p += corr_term(x, y, 10, 4, 6, 5, 5, OP_OR);
    p += corr_term(x, y, 11, 4, 7, 5, 6, OP_AND);
    p += corr_term(x, y, 11, 4, 7, 5, 6, OP_OR);
    p += corr_term(x, y, 12, 5, 7, 5, 7, OP_OR);
    return p;
endfunction

// Dot product plus bias, then ReLU, shift by 6 and clip to 255.
function automatic logic [7:0] engine_result(window_t w, int bias);
    int acc;
    acc = bias;
    for (int t = 0; t < 4; t++) begin
        acc += approx_product(w.act[t], w.wgt[t]);
    end
    if (acc < 0) acc = 0;
    acc = acc >> 6;
    if (acc > 255) acc = 255;
    return 8'(acc);
endfunction

`endif

/* testbench/tb_conv_tap_engine.sv */
module tb_conv_tap_engine;
    timeunit 1ns;
    timeprecision 100ps;

    import lenet_pkg::*;

    `include "approx_model.svh"

    localparam int SEED        = 18687;
    localparam int NUM_RANDOM  = 200;
    localparam int DRAIN_LIMIT = 20;

    logic                     clk;
    logic                     arst_n;
    logic                     in_valid;
    window_t                  window;
    logic signed [BIAS_W-1:0] bias;
    logic                     out_valid;
    logic [ACT_W-1:0]         act_out;

    window_t          tab_window[$];
    int               tab_bias[$];
    logic [ACT_W-1:0] tab_expect[$];
    int               tab_gap[$];

    logic [ACT_W-1:0] exp_value[$]; // Results still in flight.
    int               exp_cycle[$]; // Cycle in which each one must show up.

    int   cycle   = 0;
    int   errors  = 0;
    int   checked = 0;
    logic due;

    conv_tap_engine conv_tap_engine_inst (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .window    (window),
        .bias      (bias),
        .out_valid (out_valid),
        .act_out   (act_out)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    //////////////////////////////////////////////////////////////////////
    // Output checker on the falling edge
    //////////////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        due = 1'b0;
        if (exp_cycle.size() > 0) begin
            due = (exp_cycle[0] == cycle);
        end
        assert (out_valid == due) else begin
            $display("CHECK FAILED time=%0t signal=out_valid expected=%0b actual=%0b",
                     $time, due, out_valid);
            errors++;
        end
        if (due && out_valid) begin
            assert (act_out == exp_value[0]) else begin
                $display("CHECK FAILED time=%0t signal=act_out expected=%0d actual=%0d",
                         $time, exp_value[0], act_out);
                errors++;
            end
            checked++;
        end
        if (due) begin
            void'(exp_value.pop_front());
            void'(exp_cycle.pop_front());
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus table
    //////////////////////////////////////////////////////////////////////

    function automatic window_t make_window(logic [7:0] a0, logic [7:0] a1,
                                            logic [7:0] a2, logic [7:0] a3,
                                            logic [7:0] w0, logic [7:0] w1,
                                            logic [7:0] w2, logic [7:0] w3);
        window_t w;
        w.act[0] = a0;
        w.act[1] = a1;
        w.act[2] = a2;
        w.act[3] = a3;
        w.wgt[0] = w0;
        w.wgt[1] = w1;
        w.wgt[2] = w2;
        w.wgt[3] = w3;
        return w;
    endfunction

    task automatic add_entry(input window_t w, input int b, input logic [7:0] e,
                             input int gap);
        tab_window.push_back(w);
        tab_bias.push_back(b);
        tab_expect.push_back(e);
        tab_gap.push_back(gap);
    endtask

    // Hand-computed entry; the model must agree with it as well.
    task automatic add_directed(input window_t w, input int b, input logic [7:0] e,
                                input int gap);
        assert (engine_result(w, b) == e) else begin
            $display("Model disagrees with directed entry %0d", tab_window.size());
            errors++;
        end
        add_entry(w, b, e, gap);
    endtask

    task automatic build_table();
        window_t w;
        int      b;
        add_directed(make_window(8'h40, 8'h80, 8'hC0, 8'h40, 8'd10, 8'd20, 8'd30, 8'd40),
                     0, 8'd180, 0);
        add_directed(make_window(8'h80, 8'h00, 8'h40, 8'hC0, 8'd100, 8'd50, 8'd3, 8'd7),
                     -5000, 8'd145, 1);
        add_directed(make_window(8'h40, 8'h40, 8'h00, 8'h00, 8'd1, 8'd2, 8'd0, 8'd0),
                     -1000, 8'd0, 0);
        add_directed(make_window(8'h80, 8'h80, 8'h80, 8'h80, 8'd1, 8'd2, 8'd3, 8'd4),
                     64, 8'd21, 2);
        add_directed(make_window(8'hFF, 8'hFF, 8'hFF, 8'hFF, 8'd0, 8'd0, 8'd0, 8'd0),
                     12345, 8'd192, 0);
        add_directed(make_window(8'hFF, 8'hFF, 8'hFF, 8'hFF, 8'd0, 8'd0, 8'd0, 8'd0),
                     -12345, 8'd0, 0);
        add_directed(make_window(8'h00, 8'h00, 8'h00, 8'h00, 8'hFF, 8'hFF, 8'hFF, 8'hFF),
                     640, 8'd10, 1);
        add_directed(make_window(8'hFF, 8'hFF, 8'hFF, 8'hFF, 8'hFF, 8'hFF, 8'hFF, 8'hFF),
                     100000, 8'd255, 0);
        add_directed(make_window(8'hC0, 8'hC0, 8'hC0, 8'hC0, 8'hFF, 8'hFF, 8'hFF, 8'hFF),
                     0, 8'd255, 3);
        for (int i = 0; i < NUM_RANDOM; i++) begin
            for (int t = 0; t < TAPS; t++) begin
                w.act[t] = 8'($urandom);
                w.wgt[t] = (i % 2 == 1) ? 8'($urandom_range(0, 31)) : 8'($urandom);
            end
            b = int'($urandom_range(0, 16383)) - 8192;
            add_entry(w, b, engine_result(w, b), (i % 4 == 3) ? 2 : 0);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Driving and draining
    //////////////////////////////////////////////////////////////////////

    task automatic drive_window(input window_t w, input int b, input logic [7:0] e);
        window   = w;
        bias     = BIAS_W'(b);
        in_valid = 1'b1;
        exp_value.push_back(e);
        exp_cycle.push_back(cycle + 2); // Two edges of pipeline after this cycle.
        @(posedge clk);
        #1;
        in_valid = 1'b0;
    endtask

    task automatic wait_for_drain();
        int waited;
        waited = 0;
        while (exp_cycle.size() > 0 && waited < DRAIN_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        assert (exp_cycle.size() == 0) else begin
            $display("Timeout: %0d results never appeared on out_valid", exp_cycle.size());
            errors += exp_cycle.size();
        end
        repeat (3) @(negedge clk); // Output must stay idle.
    endtask

    initial begin
        void'($urandom(SEED));
        clk      = 1'b0;
        arst_n   = 1'b0;
        in_valid = 1'b0;
        window   = '0;
        bias     = '0;
        build_table();
        repeat (2) @(posedge clk);
        #1;
        arst_n = 1'b1;
        repeat (4) @(posedge clk); // The engine idles after reset with out_valid low.
        #1;
        for (int i = 0; i < tab_window.size(); i++) begin
            drive_window(tab_window[i], tab_bias[i], tab_expect[i]);
            repeat (tab_gap[i]) begin
                @(posedge clk);
                #1;
            end
        end
        wait_for_drain();
        $display("errors: %0d, results checked: %0d", errors, checked);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule
